//--- source/awb_pkg.sv
package awb_pkg;

////////////////////////////////////////////////////////////
// Widths
////////////////////////////////////////////////////////////

localparam int PX_WIDTH      = 10;
localparam int FRACT_WIDTH   = 10;
localparam int COEF_WIDTH    = PX_WIDTH + FRACT_WIDTH;
localparam int PROD_WIDTH    = PX_WIDTH + COEF_WIDTH;
localparam int DIV_CNT_WIDTH = $clog2( COEF_WIDTH + 1 );

typedef logic [PX_WIDTH - 1 : 0]      pixel_t;
typedef logic [COEF_WIDTH - 1 : 0]    coef_t;
typedef logic [PROD_WIDTH - 1 : 0]    prod_t;
typedef logic [DIV_CNT_WIDTH - 1 : 0] div_cnt_t;

// Gain of 1.0 in fixed point.
localparam coef_t GAIN_UNITY = coef_t'( 1 ) << FRACT_WIDTH;

////////////////////////////////////////////////////////////
// Stream beat
////////////////////////////////////////////////////////////

typedef struct packed {
  pixel_t r;
  pixel_t g;
  pixel_t b;
} rgb_t;

typedef struct packed {
  logic sof;
  logic eol;
  rgb_t px;
} video_beat_t;

typedef enum logic {
  DIV_IDLE,
  DIV_BUSY
} div_state_t;

endpackage

//--- source/awb_divider.sv
`timescale 1ns/1ps

module awb_divider
  import awb_pkg::*;
(
  input  logic  clk_i,
  input  logic  rst_i,
  input  logic  start_i,
  input  coef_t dividend_i,
  input  coef_t divisor_i,
  output logic  done_o,
  output coef_t quotient_o
);

div_state_t            state;
div_cnt_t              bit_cnt;
coef_t                 divisor;
coef_t                 rem;
coef_t                 quot;
logic                  div_zero;
logic                  fits;
logic [COEF_WIDTH : 0] rem_shifted;
logic [COEF_WIDTH : 0] rem_diff;

// Bring down the next dividend bit.
assign rem_shifted = { rem, quot[COEF_WIDTH - 1] };
assign rem_diff    = rem_shifted - { 1'b0, divisor };
assign fits        = ( rem_shifted >= { 1'b0, divisor } );

always_ff @( posedge clk_i, posedge rst_i )
  if( rst_i )
    begin
      state   <= DIV_IDLE;
      bit_cnt <= '0;
      done_o  <= 1'b0;
    end
  else
    begin
      done_o <= 1'b0;
      case( state )
        DIV_IDLE:
          if( start_i )
            begin
              state   <= DIV_BUSY;
              bit_cnt <= '0;
            end
        DIV_BUSY:
          if( bit_cnt == div_cnt_t'( COEF_WIDTH ) )
            begin
              state  <= DIV_IDLE;
              done_o <= 1'b1;
            end
          else
            bit_cnt <= bit_cnt + 1'b1;
        default:
          state <= DIV_IDLE;
      endcase
    end

// One quotient bit per cycle, then a finishing cycle.
always_ff @( posedge clk_i )
  if( state == DIV_IDLE && start_i )
    begin
      divisor  <= divisor_i;
      div_zero <= ( divisor_i == '0 );
      rem      <= '0;
      quot     <= dividend_i;
    end
  else if( state == DIV_BUSY )
    if( bit_cnt == div_cnt_t'( COEF_WIDTH ) )
      quotient_o <= div_zero ? '1 : quot;
    else
      begin
        rem  <= fits ? rem_diff[COEF_WIDTH - 1 : 0] : rem_shifted[COEF_WIDTH - 1 : 0];
        quot <= { quot[COEF_WIDTH - 2 : 0], fits };
      end

endmodule

//--- source/awb_retinex.sv
`timescale 1ns/1ps

module awb_retinex
  import awb_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_i,
  input  video_beat_t beat_i,
  input  logic        beat_fire_i,
  output coef_t       r_gain_o,
  output coef_t       b_gain_o
);

rgb_t  px_max;
rgb_t  max_snap;
logic  div_start;
coef_t g_dividend;
coef_t r_quot;
coef_t b_quot;
logic  r_done;
logic  b_done;

////////////////////////////////////////////////////////////
// Per-frame maxima
////////////////////////////////////////////////////////////

always_ff @( posedge clk_i, posedge rst_i )
  if( rst_i )
    px_max <= '0;
  else
    if( beat_fire_i )
      if( beat_i.sof )
        px_max <= beat_i.px;
      else
        begin
          if( beat_i.px.r > px_max.r )
            px_max.r <= beat_i.px.r;
          if( beat_i.px.g > px_max.g )
            px_max.g <= beat_i.px.g;
          if( beat_i.px.b > px_max.b )
            px_max.b <= beat_i.px.b;
        end

// Frame start freezes last frame's maxima for the dividers.
always_ff @( posedge clk_i )
  if( beat_fire_i && beat_i.sof )
    max_snap <= px_max;

always_ff @( posedge clk_i, posedge rst_i )
  if( rst_i )
    div_start <= 1'b0;
  else
    div_start <= beat_fire_i && beat_i.sof;

assign g_dividend = coef_t'( max_snap.g ) << FRACT_WIDTH;

////////////////////////////////////////////////////////////
// Gain dividers
////////////////////////////////////////////////////////////

awb_divider r_gain_div (
  .clk_i      ( clk_i                  ),
  .rst_i      ( rst_i                  ),
  .start_i    ( div_start              ),
  .dividend_i ( g_dividend             ),
  .divisor_i  ( coef_t'( max_snap.r )  ),
  .done_o     ( r_done                 ),
  .quotient_o ( r_quot                 )
);

awb_divider b_gain_div (
  .clk_i      ( clk_i                  ),
  .rst_i      ( rst_i                  ),
  .start_i    ( div_start              ),
  .dividend_i ( g_dividend             ),
  .divisor_i  ( coef_t'( max_snap.b )  ),
  .done_o     ( b_done                 ),
  .quotient_o ( b_quot                 )
);

always_ff @( posedge clk_i, posedge rst_i )
  if( rst_i )
    begin
      r_gain_o <= GAIN_UNITY;
      b_gain_o <= GAIN_UNITY;
    end
  else
    begin
      if( r_done )
        r_gain_o <= r_quot;
      if( b_done )
        b_gain_o <= b_quot;
    end

endmodule

//--- source/awb_gain_apply.sv
`timescale 1ns/1ps

module awb_gain_apply
  import awb_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_i,
  input  video_beat_t in_beat_i,
  input  logic        in_valid_i,
  output logic        in_ready_o,
  input  coef_t       r_gain_i,
  input  coef_t       b_gain_i,
  output video_beat_t out_beat_o,
  output logic        out_valid_o,
  input  logic        out_ready_i
);

coef_t  r_gain_work;
coef_t  b_gain_work;
coef_t  r_gain_sel;
coef_t  b_gain_sel;
logic   in_fire;
logic   s1_valid;
logic   s1_ready;
logic   s2_ready;
logic   s1_sof;
logic   s1_eol;
pixel_t s1_g;
prod_t  s1_r_prod;
prod_t  s1_b_prod;

function automatic pixel_t sat_px( prod_t prod );
  if( |prod[PROD_WIDTH - 1 : FRACT_WIDTH + PX_WIDTH] )
    return '1;
  else
    return prod[FRACT_WIDTH +: PX_WIDTH];
endfunction

assign s2_ready   = !out_valid_o || out_ready_i;
assign s1_ready   = !s1_valid || s2_ready;
assign in_ready_o = s1_ready;
assign in_fire    = in_valid_i && s1_ready;

// A frame's first beat already uses the new gains.
assign r_gain_sel = in_beat_i.sof ? r_gain_i : r_gain_work;
assign b_gain_sel = in_beat_i.sof ? b_gain_i : b_gain_work;

always_ff @( posedge clk_i, posedge rst_i )
  if( rst_i )
    begin
      s1_valid    <= 1'b0;
      out_valid_o <= 1'b0;
      r_gain_work <= GAIN_UNITY;
      b_gain_work <= GAIN_UNITY;
    end
  else
    begin
      if( s1_ready )
        s1_valid <= in_valid_i;
      if( s2_ready )
        out_valid_o <= s1_valid;
      if( in_fire && in_beat_i.sof )
        begin
          r_gain_work <= r_gain_i;
          b_gain_work <= b_gain_i;
        end
    end

////////////////////////////////////////////////////////////
// Multiply, then shift and saturate
////////////////////////////////////////////////////////////

always_ff @( posedge clk_i )
  begin
    if( in_fire )
      begin
        s1_sof    <= in_beat_i.sof;
        s1_eol    <= in_beat_i.eol;
        s1_g      <= in_beat_i.px.g;
        s1_r_prod <= in_beat_i.px.r * r_gain_sel;
        s1_b_prod <= in_beat_i.px.b * b_gain_sel;
      end
    if( s1_valid && s2_ready )
      begin
        out_beat_o.sof  <= s1_sof;
        out_beat_o.eol  <= s1_eol;
        out_beat_o.px.g <= s1_g;
        out_beat_o.px.r <= sat_px( s1_r_prod );
        out_beat_o.px.b <= sat_px( s1_b_prod );
      end
  end

endmodule

//--- source/awb_top.sv
`timescale 1ns/1ps

module awb_top
  import awb_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_i,
  input  video_beat_t in_beat_i,
  input  logic        in_valid_i,
  output logic        in_ready_o,
  output video_beat_t out_beat_o,
  output logic        out_valid_o,
  input  logic        out_ready_i,
  output coef_t       r_gain_o,
  output coef_t       b_gain_o
);

logic beat_fire;

// Statistics see exactly the beats the gain stage accepts.
assign beat_fire = in_valid_i && in_ready_o;

awb_retinex awb_retinex_i (
  .clk_i       ( clk_i      ),
  .rst_i       ( rst_i      ),
  .beat_i      ( in_beat_i  ),
  .beat_fire_i ( beat_fire  ),
  .r_gain_o    ( r_gain_o   ),
  .b_gain_o    ( b_gain_o   )
);

awb_gain_apply awb_gain_apply_i (
  .clk_i       ( clk_i       ),
  .rst_i       ( rst_i       ),
  .in_beat_i   ( in_beat_i   ),
  .in_valid_i  ( in_valid_i  ),
  .in_ready_o  ( in_ready_o  ),
  .r_gain_i    ( r_gain_o    ),
  .b_gain_i    ( b_gain_o    ),
  .out_beat_o  ( out_beat_o  ),
  .out_valid_o ( out_valid_o ),
  .out_ready_i ( out_ready_i )
);

endmodule

//--- test/awb_sva.sv
`timescale 1ns/1ps

module awb_sva
  import awb_pkg::*;
(
  input logic        clk_i,
  input logic        rst_i,
  input logic        in_valid_i,
  input logic        in_ready_i,
  input video_beat_t out_beat_i,
  input logic        out_valid_i,
  input logic        out_ready_i
);

int fail_cnt = 0;

// Stalled output keeps its beat.
stall_stable: assert property ( @( posedge clk_i ) disable iff ( rst_i )
  out_valid_i && !out_ready_i |=> out_valid_i && $stable( out_beat_i ) )
  else
    begin
      fail_cnt++;
      $error( "out_beat_o changed under back-pressure" );
    end

// Two quiet cycles out of reset.
reset_quiet: assert property ( @( posedge clk_i )
  !rst_i && ( $past( rst_i ) || $past( rst_i, 2 ) ) |-> !out_valid_i )
  else
    begin
      fail_cnt++;
      $error( "out_valid_o high too early after reset" );
    end

// A beat taken behind a stalled output fills the pipe.
full_stall: assert property ( @( posedge clk_i ) disable iff ( rst_i )
  in_valid_i && in_ready_i && out_valid_i && !out_ready_i |=> !in_ready_i || out_ready_i )
  else
    begin
      fail_cnt++;
      $error( "in_ready_o high with both stages full" );
    end

endmodule

bind awb_gain_apply awb_sva awb_sva_i (
  .clk_i       ( clk_i       ),
  .rst_i       ( rst_i       ),
  .in_valid_i  ( in_valid_i  ),
  .in_ready_i  ( in_ready_o  ),
  .out_beat_i  ( out_beat_o  ),
  .out_valid_i ( out_valid_o ),
  .out_ready_i ( out_ready_i )
);

//--- test/awb_tb.sv
`timescale 1ns/1ps

module awb_tb
  import awb_pkg::*;
();

logic        clk_i = 1'b0;
logic        rst_i;
video_beat_t in_beat_i;
logic        in_valid_i;
logic        in_ready_o;
video_beat_t out_beat_o;
logic        out_valid_o;
logic        out_ready_i;
coef_t       r_gain_o;
coef_t       b_gain_o;

video_beat_t in_q[$];
video_beat_t exp_q[$];
logic        chk_q[$];
coef_t       r_gain_q[$];
coef_t       b_gain_q[$];
int          beat_errors  = 0;
int          gain_errors  = 0;
int          other_errors = 0;
int          out_cnt      = 0;
int          cycle_cnt    = 0;
int          cycle_limit  = 200;
logic [31:0] drive_seed   = 32'h4eba;
logic [31:0] sink_seed    = 32'h4eba;

always #50 clk_i = ~clk_i;

awb_top awb_top_i (
  .clk_i       ( clk_i       ),
  .rst_i       ( rst_i       ),
  .in_beat_i   ( in_beat_i   ),
  .in_valid_i  ( in_valid_i  ),
  .in_ready_o  ( in_ready_o  ),
  .out_beat_o  ( out_beat_o  ),
  .out_valid_o ( out_valid_o ),
  .out_ready_i ( out_ready_i ),
  .r_gain_o    ( r_gain_o    ),
  .b_gain_o    ( b_gain_o    )
);

function automatic logic [31:0] lcg_next( logic [31:0] seed );
  return seed * 32'd1664525 + 32'd1013904223;
endfunction

task automatic check_beat( string name, video_beat_t act, video_beat_t expected );
  if( act !== expected )
    begin
      beat_errors++;
      $display( "[FAIL] %0t %s: got %h, expected %h", $time, name, act, expected );
    end
endtask

task automatic check_gain( string name, coef_t act, coef_t expected );
  if( act !== expected )
    begin
      gain_errors++;
      $display( "[FAIL] %0t %s: got %h, expected %h", $time, name, act, expected );
    end
endtask

////////////////////////////////////////////////////////////
// Stimulus from the data file
////////////////////////////////////////////////////////////

// Each record is one video line of six equal pixels.
task automatic load_testdata();
  int          fd;
  int          i;
  string       line;
  coef_t       col[10];
  video_beat_t beat;
  video_beat_t exp_beat;
  fd = $fopen( "test/awb_testdata.txt", "r" );
  if( fd == 0 )
    return;
  while( !$feof( fd ) )
    begin
      line = "";
      void'( $fgets( line, fd ) );
      if( $sscanf( line, "%h %h %h %h %h %h %h %h %h %h",
                   col[0], col[1], col[2], col[3], col[4],
                   col[5], col[6], col[7], col[8], col[9] ) == 10 )
        for( i = 0; i < 6; i++ )
          begin
            beat.sof     = col[0][0] && ( i == 0 );
            beat.eol     = ( i == 5 );
            beat.px      = { pixel_t'( col[1] ), pixel_t'( col[2] ), pixel_t'( col[3] ) };
            exp_beat     = beat;
            exp_beat.px  = { pixel_t'( col[4] ), pixel_t'( col[5] ), pixel_t'( col[6] ) };
            in_q.push_back( beat );
            exp_q.push_back( exp_beat );
            chk_q.push_back( beat.sof && col[7][0] );
            r_gain_q.push_back( col[8] );
            b_gain_q.push_back( col[9] );
          end
    end
  $fclose( fd );
endtask

// Gains are sampled before the edge that moves a frame start beat.
task automatic send_beat( int idx );
  logic accepted;
  accepted   = 1'b0;
  drive_seed = lcg_next( drive_seed );
  if( drive_seed[31:30] == 2'd0 )
    begin
      in_valid_i = 1'b0;
      @( posedge clk_i );
      #1;
    end
  in_beat_i  = in_q[idx];
  in_valid_i = 1'b1;
  while( !accepted )
    begin
      @( negedge clk_i );
      accepted = in_ready_o;
      if( accepted && chk_q[idx] )
        begin
          check_gain( "r_gain_o", r_gain_o, r_gain_q[idx] );
          check_gain( "b_gain_o", b_gain_o, b_gain_q[idx] );
        end
      @( posedge clk_i );
      #1;
    end
endtask

////////////////////////////////////////////////////////////
// Output sink, monitor and timeout
////////////////////////////////////////////////////////////

always @( posedge clk_i )
  begin
    #1;
    sink_seed   = lcg_next( sink_seed );
    out_ready_i = ( sink_seed[31:30] != 2'd0 );
  end

always @( negedge clk_i )
  if( !rst_i && out_valid_o && out_ready_i )
    begin
      if( out_cnt < exp_q.size() )
        check_beat( "out_beat_o", out_beat_o, exp_q[out_cnt] );
      else
        begin
          other_errors++;
          $display( "Output beat %0d has no matching input beat", out_cnt );
        end
      out_cnt++;
    end

always @( posedge clk_i )
  begin
    cycle_cnt++;
    if( cycle_cnt > cycle_limit )
      begin
        $display( "Run stopped by timeout after %0d cycles", cycle_cnt );
        $display( "Something failed" );
        $finish;
      end
  end

initial
  begin
    int i;
    int assert_errors;
    rst_i       = 1'b1;
    in_valid_i  = 1'b0;
    in_beat_i   = '0;
    out_ready_i = 1'b0;
    load_testdata();
    cycle_limit = 4 * in_q.size() + 200;
    repeat( 10 ) @( posedge clk_i );
    #1;
    rst_i = 1'b0;
    for( i = 0; i < in_q.size(); i++ )
      send_beat( i );
    in_valid_i = 1'b0;
    while( out_cnt < exp_q.size() )
      @( posedge clk_i );
    // Room for a stray extra beat.
    repeat( 10 ) @( posedge clk_i );
    if( in_q.size() == 0 )
      begin
        other_errors++;
        $display( "No records read from test/awb_testdata.txt" );
      end
    assert_errors = awb_top_i.awb_gain_apply_i.awb_sva_i.fail_cnt;
    $display( "Errors: beat %0d, gain %0d, other %0d, assertion %0d",
              beat_errors, gain_errors, other_errors, assert_errors );
    if( beat_errors + gain_errors + other_errors + assert_errors == 0 )
      $display( "Everything OK" );
    else
      $display( "Something failed" );
    $finish;
  end

endmodule

//--- test/awb_testdata.txt
// Hex columns: sof, in r g b, expected r g b, gain check, expected r_gain b_gain.
// One record is a line of six equal pixels; four records make a frame.
1 190 12C 0C8 190 12C 0C8 1 00400 00400
0 064 200 096 064 200 096 0 00000 00000
0 0C8 064 100 0C8 064 100 0 00000 00000
0 032 03C 046 032 03C 046 0 00000 00000
1 014 258 000 3FF 258 000 1 FFFFF FFFFF
0 00A 190 000 3FF 190 000 0 00000 00000
0 005 0C8 000 3FF 0C8 000 0 00000 00000
0 000 064 000 000 064 000 0 00000 00000
1 12C 12C 064 17F 12C 0C8 1 0051E 00800
0 258 320 190 2FF 320 320 0 00000 00000
0 3E8 0C8 032 3FF 0C8 064 0 00000 00000
0 064 032 258 07F 032 3FF 0 00000 00000
1 01E 1F4 00A 384 1F4 3FF 1 07800 FFFFF
0 064 2BC 000 3FF 2BC 000 0 00000 00000
0 022 12C 001 3FC 12C 3FF 0 00000 00000
0 001 014 384 01E 014 3FF 0 00000 00000
1 3E8 3E8 3E8 31F 3E8 3FF 1 00333 00555
0 200 00A 100 199 00A 155 0 00000 00000
0 000 000 000 000 000 000 0 00000 00000
0 3FF 3FF 2BC 332 3FF 3A5 0 00000 00000

//--- flist.f
source/awb_pkg.sv
source/awb_divider.sv
source/awb_retinex.sv
source/awb_gain_apply.sv
source/awb_top.sv
test/awb_sva.sv
test/awb_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e
set -o pipefail

verilator --binary --timing --assert -j 0 --top-module awb_tb -f flist.f
./obj_dir/Vawb_tb +verilator+error+limit+1000 2>&1 | tee sim.log

if grep -q "Something failed" sim.log; then
  echo "Simulation reported a failure"
  exit 1
fi
echo "Simulation finished without failure"
